//--- common/rename_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register and tag widths, tag types, rename request and response
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package rename_pkg;

    // Architectural register file of the ISA
    localparam int ARCH_REG_W    = 5;
    localparam int NUM_ARCH_REGS = 32;

    // Physical tag space, room for up to 64 registers
    localparam int PHYS_TAG_W    = 6;

    // Architectural register number
    typedef logic [ARCH_REG_W-1:0] arch_reg_t;

    // Physical register tag
    typedef logic [PHYS_TAG_W-1:0] phys_tag_t;

    // Decoded register fields, from decode
    // 15 bits
    typedef struct packed {
        arch_reg_t rs1;
        arch_reg_t rs2;
        arch_reg_t rd;
    } rename_req_t;

    // Renamed operands, toward dispatch
    // 26 bits
    typedef struct packed {
        // Source tags from the alias table
        phys_tag_t prs1;
        phys_tag_t prs2;
        // Fresh destination tag, 0 when rd is x0
        phys_tag_t prd;
        // Previous mapping of rd, returned at commit
        phys_tag_t old_prd;
        // Source operands already produced
        logic      rs1_ready;
        logic      rs2_ready;
    } rename_rsp_t;

endpackage

`default_nettype wire

//--- design/rename_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Rename stage top, free list, alias table, busy table, response reg
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module rename_stage #(
    parameter int NUM_PHYS_REGS = 64
) (
    input  wire logic                    clk_i,
    input  wire logic                    reset_i,
    // Decode side
    input  wire logic                    ren_valid_i,
    input  wire rename_pkg::rename_req_t ren_req_i,
    output logic                         stall_o,
    // Dispatch side, one cycle after acceptance
    output logic                         rsp_valid_o,
    output rename_pkg::rename_rsp_t      rsp_o,
    // Common data bus wake-up
    input  wire logic                    cdb_valid_i,
    input  wire rename_pkg::phys_tag_t   cdb_tag_i,
    // Tags released at commit
    input  wire logic                    commit_valid_i,
    input  wire rename_pkg::phys_tag_t   commit_tag_i
);

    logic accept;
    logic rd_nz;
    logic alloc;
    logic fl_empty;

    rename_pkg::phys_tag_t head_tag;
    rename_pkg::phys_tag_t prs1;
    rename_pkg::phys_tag_t prs2;
    rename_pkg::phys_tag_t old_prd;
    logic                  rs1_ready;
    logic                  rs2_ready;

    rename_pkg::rename_rsp_t rsp_d;
    rename_pkg::rename_rsp_t rsp_q;
    logic                    rsp_valid_q;

    // Stall on an empty list, whatever rd is
    assign stall_o = fl_empty;
    assign accept  = ren_valid_i && !stall_o;
    // x0 writes take no tag
    assign rd_nz   = (ren_req_i.rd != '0);
    assign alloc   = accept && rd_nz;

    free_list #(
        .NUM_PHYS_REGS (NUM_PHYS_REGS)
    ) u_free_list (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .alloc_i    (alloc),
        .free_i     (commit_valid_i),
        .free_tag_i (commit_tag_i),
        .head_tag_o (head_tag),
        .empty_o    (fl_empty)
    );

    // Head tag becomes the new mapping of rd
    reg_alias_table u_rat (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .rs1_i     (ren_req_i.rs1),
        .rs2_i     (ren_req_i.rs2),
        .rd_i      (ren_req_i.rd),
        .wr_en_i   (alloc),
        .wr_tag_i  (head_tag),
        .prs1_o    (prs1),
        .prs2_o    (prs2),
        .old_prd_o (old_prd)
    );

    // New destination turns busy, CDB clears it
    busy_table #(
        .NUM_PHYS_REGS (NUM_PHYS_REGS)
    ) u_busy_table (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .set_i     (alloc),
        .set_tag_i (head_tag),
        .clr_i     (cdb_valid_i),
        .clr_tag_i (cdb_tag_i),
        .tag_a_i   (prs1),
        .tag_b_i   (prs2),
        .ready_a_o (rs1_ready),
        .ready_b_o (rs2_ready)
    );

    // Response from the pre-update mapping
    always_comb begin
        rsp_d.prs1      = prs1;
        rsp_d.prs2      = prs2;
        rsp_d.prd       = rd_nz ? head_tag : '0;
        rsp_d.old_prd   = rd_nz ? old_prd : '0;
        rsp_d.rs1_ready = rs1_ready;
        rsp_d.rs2_ready = rs2_ready;
    end

    // Valid one clock after acceptance
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= accept;
        end
    end

    // Payload captured only on an accepted request
    always_ff @(posedge clk_i) begin
        if (accept) begin
            rsp_q <= rsp_d;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;

endmodule

`default_nettype wire

//--- files.f
common/rename_pkg.sv
rename/free_list.sv
rename/reg_alias_table.sv
rename/busy_table.sv
design/rename_stage.sv
sim/rename_tb.sv

//--- rename/busy_table.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Busy table, one pending bit per physical tag with CDB bypass
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module busy_table #(
    parameter int NUM_PHYS_REGS = 64
) (
    input  wire logic                  clk_i,
    input  wire logic                  reset_i,
    // Tag allocated to a new destination
    input  wire logic                  set_i,
    input  wire rename_pkg::phys_tag_t set_tag_i,
    // Result broadcast on the CDB
    input  wire logic                  clr_i,
    input  wire rename_pkg::phys_tag_t clr_tag_i,
    // Source lookups
    input  wire rename_pkg::phys_tag_t tag_a_i,
    input  wire rename_pkg::phys_tag_t tag_b_i,
    output logic                       ready_a_o,
    output logic                       ready_b_o
);

    // High while the tag's producer is still in flight
    logic [NUM_PHYS_REGS-1:0] pend_q;

    // Ready when not pending or broadcast right now
    function automatic logic tag_ready(input rename_pkg::phys_tag_t tag);
        logic hit;
        hit = clr_i && (clr_tag_i == tag);
        return !pend_q[tag] || hit;
    endfunction

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            // Every tag holds a value after reset
            pend_q <= '0;
        end else begin
            if (clr_i) begin
                pend_q[clr_tag_i] <= 1'b0;
            end
            // Later assignment, so set beats clear on the same tag
            // Tag 0 stays ready forever
            if (set_i && (set_tag_i != '0)) begin
                pend_q[set_tag_i] <= 1'b1;
            end
        end
    end

    assign ready_a_o = tag_ready(tag_a_i);
    assign ready_b_o = tag_ready(tag_b_i);

endmodule

`default_nettype wire

//--- rename/free_list.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Free list of unallocated physical tags, circular FIFO with count
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module free_list #(
    parameter int NUM_PHYS_REGS = 64
) (
    input  wire logic              clk_i,
    input  wire logic              reset_i,
    // Pop the head tag
    input  wire logic              alloc_i,
    // Push a committed tag
    input  wire logic              free_i,
    input  wire rename_pkg::phys_tag_t free_tag_i,
    // Next tag to hand out
    output rename_pkg::phys_tag_t  head_tag_o,
    output logic                   empty_o
);

    // Tags above the architectural range start out free
    localparam int DEPTH = NUM_PHYS_REGS - rename_pkg::NUM_ARCH_REGS;
    // Keep a 1-bit pointer even for a single entry
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    // Tag storage
    rename_pkg::phys_tag_t fifo_q [DEPTH];

    // Read side
    ptr_t head_q;
    // Write side
    ptr_t tail_q;
    // Entries currently held
    cnt_t count_q;

    logic pop;
    logic push;
    logic full;

    // Wrap at DEPTH, which need not be a power of two
    function automatic ptr_t ptr_next(input ptr_t ptr);
        return (ptr == ptr_t'(DEPTH - 1)) ? ptr_t'(0) : ptr + ptr_t'(1);
    endfunction

    assign empty_o = (count_q == cnt_t'(0));
    assign full    = (count_q == cnt_t'(DEPTH));

    // Never pop an empty list
    assign pop  = alloc_i && !empty_o;
    // A full list can only take a tag while it also pops
    assign push = free_i && (!full || pop);

    // Head entry is the next allocation
    assign head_tag_o = fifo_q[head_q];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            // Full list, tags 32 upward in order
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= cnt_t'(DEPTH);
            for (int i = 0; i < DEPTH; i++) begin
                fifo_q[i] <= rename_pkg::phys_tag_t'(rename_pkg::NUM_ARCH_REGS + i);
            end
        end else begin
            if (pop) begin
                head_q <= ptr_next(head_q);
            end
            if (push) begin
                fifo_q[tail_q] <= free_tag_i;
                tail_q         <= ptr_next(tail_q);
            end
            // Pop and push together leave the count alone
            case ({push, pop})
                2'b10:   count_q <= count_q + cnt_t'(1);
                2'b01:   count_q <= count_q - cnt_t'(1);
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rename/reg_alias_table.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register alias table, architectural to physical tag mapping
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module reg_alias_table (
    input  wire logic                  clk_i,
    input  wire logic                  reset_i,
    // Lookup addresses
    input  wire rename_pkg::arch_reg_t rs1_i,
    input  wire rename_pkg::arch_reg_t rs2_i,
    input  wire rename_pkg::arch_reg_t rd_i,
    // Remap rd to a new tag
    input  wire logic                  wr_en_i,
    input  wire rename_pkg::phys_tag_t wr_tag_i,
    // Mapping before this cycle's write
    output rename_pkg::phys_tag_t      prs1_o,
    output rename_pkg::phys_tag_t      prs2_o,
    output rename_pkg::phys_tag_t      old_prd_o
);

    // One tag per architectural register
    rename_pkg::phys_tag_t map_q [rename_pkg::NUM_ARCH_REGS];

    // x0 is never remapped
    logic wr_ok;

    assign wr_ok = wr_en_i && (rd_i != '0);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            // Identity mapping, r -> tag r
            for (int r = 0; r < rename_pkg::NUM_ARCH_REGS; r++) begin
                map_q[r] <= rename_pkg::phys_tag_t'(r);
            end
        end else if (wr_ok) begin
            // Visible to the next request
            map_q[rd_i] <= wr_tag_i;
        end
    end

    // Three combinational read ports
    // Entry 0 holds tag 0 from reset on
    assign prs1_o    = map_q[rs1_i];
    assign prs2_o    = map_q[rs2_i];
    // Tag rd held before the rename, freed at commit
    assign old_prd_o = map_q[rd_i];

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the rename stage testbench with Verilator, run it, check the log

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module rename_tb -f files.f -o rename_sim > "$LOG" 2>&1 \
    && ./obj_dir/rename_sim >> "$LOG" 2>&1 \
    || { cat "$LOG"; echo "Build or run failed"; exit 1; }

cat "$LOG"
grep -q "Simulation finished: FAIL" "$LOG" && exit 1
grep -q "Simulation finished: PASS" "$LOG" || exit 1
exit 0

//--- sim/rename_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Rename stage testbench, reference model, directed and random tests
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module rename_tb;

    // 8 free tags, so the list empties quickly
    localparam int NUM_PHYS        = 40;
    localparam int RESET_CYCLES    = 4;
    localparam int DIRECTED_CYCLES = 31;
    localparam int RANDOM_CYCLES   = 400;
    // Last response lands two edges after its drive, checked one edge later
    localparam int DRAIN_CYCLES    = 3;
    localparam int TIMEOUT_CYCLES  =
        2 * (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + DRAIN_CYCLES);

    logic                    clk_i;
    logic                    reset_i;
    logic                    ren_valid_i;
    rename_pkg::rename_req_t ren_req_i;
    logic                    stall_o;
    logic                    rsp_valid_o;
    rename_pkg::rename_rsp_t rsp_o;
    logic                    cdb_valid_i;
    rename_pkg::phys_tag_t   cdb_tag_i;
    logic                    commit_valid_i;
    rename_pkg::phys_tag_t   commit_tag_i;

    // Reference model state
    rename_pkg::phys_tag_t alias_m [rename_pkg::NUM_ARCH_REGS];
    logic [NUM_PHYS-1:0]   busy_m;
    rename_pkg::phys_tag_t free_m [$];
    // Overwritten mappings, waiting for commit
    rename_pkg::phys_tag_t retired_m [$];

    // Expected response, one stage behind the drive like the DUT
    logic                    pend_valid = 1'b0;
    rename_pkg::rename_rsp_t pend_rsp;
    logic                    exp_valid;
    rename_pkg::rename_rsp_t exp_rsp;
    logic                    exp_stall = 1'b0;

    int errors = 0;
    int checks = 0;
    int cycles = 0;

    rename_stage #(
        .NUM_PHYS_REGS (NUM_PHYS)
    ) dut (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .ren_valid_i    (ren_valid_i),
        .ren_req_i      (ren_req_i),
        .stall_o        (stall_o),
        .rsp_valid_o    (rsp_valid_o),
        .rsp_o          (rsp_o),
        .cdb_valid_i    (cdb_valid_i),
        .cdb_tag_i      (cdb_tag_i),
        .commit_valid_i (commit_valid_i),
        .commit_tag_i   (commit_tag_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    task automatic count_mismatch(input string name, input logic [7:0] got,
                                  input logic [7:0] want);
        errors++;
        $display("** Error: %s = %0h, expected %0h at %0t", name, got, want, $time);
    endtask

    // Identity mapping, all ready, tags 32 upward free
    task automatic model_reset();
        free_m.delete();
        retired_m.delete();
        busy_m = '0;
        for (int r = 0; r < rename_pkg::NUM_ARCH_REGS; r++) begin
            alias_m[r] = rename_pkg::phys_tag_t'(r);
        end
        for (int t = rename_pkg::NUM_ARCH_REGS; t < NUM_PHYS; t++) begin
            free_m.push_back(rename_pkg::phys_tag_t'(t));
        end
    endtask

    // One cycle of inputs, plus the model's view of that cycle
    task automatic drive(
        input logic                  ren_v,
        input rename_pkg::arch_reg_t rs1,
        input rename_pkg::arch_reg_t rs2,
        input rename_pkg::arch_reg_t rd,
        input logic                  cdb_v,
        input rename_pkg::phys_tag_t cdb_tag,
        input logic                  com_v,
        input rename_pkg::phys_tag_t com_tag
    );
        rename_pkg::rename_rsp_t rsp;
        logic                    accept;
        logic                    alloc;
        @(posedge clk_i);
        ren_valid_i    <= ren_v;
        ren_req_i      <= '{rs1: rs1, rs2: rs2, rd: rd};
        cdb_valid_i    <= cdb_v;
        cdb_tag_i      <= cdb_tag;
        commit_valid_i <= com_v;
        commit_tag_i   <= com_tag;
        // Stall is the empty free list
        exp_stall <= (free_m.size() == 0);
        accept = ren_v && (free_m.size() != 0);
        alloc  = accept && (rd != '0);
        rsp.prs1      = alias_m[rs1];
        rsp.prs2      = alias_m[rs2];
        // Same-cycle broadcast counts as ready
        rsp.rs1_ready = !busy_m[rsp.prs1] || (cdb_v && (cdb_tag == rsp.prs1));
        rsp.rs2_ready = !busy_m[rsp.prs2] || (cdb_v && (cdb_tag == rsp.prs2));
        rsp.prd       = alloc ? free_m[0] : '0;
        rsp.old_prd   = alloc ? alias_m[rd] : '0;
        pend_valid <= accept;
        pend_rsp   <= rsp;
        // State after the next edge, set wins over clear
        if (cdb_v) begin
            busy_m[cdb_tag] = 1'b0;
        end
        if (alloc) begin
            busy_m[rsp.prd] = 1'b1;
            alias_m[rd]     = rsp.prd;
            retired_m.push_back(rsp.old_prd);
            void'(free_m.pop_front());
        end
        if (com_v) begin
            free_m.push_back(com_tag);
        end
    endtask

    task automatic request(input rename_pkg::arch_reg_t rs1, input rename_pkg::arch_reg_t rs2,
                           input rename_pkg::arch_reg_t rd);
        drive(1'b1, rs1, rs2, rd, 1'b0, '0, 1'b0, '0);
    endtask

    task automatic idle();
        drive(1'b0, '0, '0, '0, 1'b0, '0, 1'b0, '0);
    endtask

    // Oldest retired tag goes back to the free list
    task automatic commit_oldest();
        rename_pkg::phys_tag_t tag;
        tag = retired_m.pop_front();
        drive(1'b0, '0, '0, '0, 1'b0, '0, 1'b1, tag);
    endtask

    // Model response lines up with rsp_o
    always @(posedge clk_i) begin
        if (reset_i) begin
            exp_valid <= 1'b0;
        end else begin
            exp_valid <= pend_valid;
            exp_rsp   <= pend_rsp;
            if (exp_valid) begin
                checks <= checks + 1;
            end
        end
    end

    assert property (@(posedge clk_i) disable iff (reset_i) rsp_valid_o == exp_valid)
    else count_mismatch("rsp_valid_o", 8'($sampled(rsp_valid_o)), 8'($sampled(exp_valid)));

    assert property (@(posedge clk_i) disable iff (reset_i) stall_o == exp_stall)
    else count_mismatch("stall_o", 8'($sampled(stall_o)), 8'($sampled(exp_stall)));

    assert property (@(posedge clk_i) disable iff (reset_i)
        exp_valid |-> rsp_o.prs1 == exp_rsp.prs1)
    else count_mismatch("rsp_o.prs1", 8'($sampled(rsp_o.prs1)), 8'($sampled(exp_rsp.prs1)));

    assert property (@(posedge clk_i) disable iff (reset_i)
        exp_valid |-> rsp_o.prs2 == exp_rsp.prs2)
    else count_mismatch("rsp_o.prs2", 8'($sampled(rsp_o.prs2)), 8'($sampled(exp_rsp.prs2)));

    assert property (@(posedge clk_i) disable iff (reset_i)
        exp_valid |-> rsp_o.prd == exp_rsp.prd)
    else count_mismatch("rsp_o.prd", 8'($sampled(rsp_o.prd)), 8'($sampled(exp_rsp.prd)));

    assert property (@(posedge clk_i) disable iff (reset_i)
        exp_valid |-> rsp_o.old_prd == exp_rsp.old_prd)
    else count_mismatch("rsp_o.old_prd", 8'($sampled(rsp_o.old_prd)),
                        8'($sampled(exp_rsp.old_prd)));

    assert property (@(posedge clk_i) disable iff (reset_i)
        exp_valid |-> rsp_o.rs1_ready == exp_rsp.rs1_ready)
    else count_mismatch("rsp_o.rs1_ready", 8'($sampled(rsp_o.rs1_ready)),
                        8'($sampled(exp_rsp.rs1_ready)));

    assert property (@(posedge clk_i) disable iff (reset_i)
        exp_valid |-> rsp_o.rs2_ready == exp_rsp.rs2_ready)
    else count_mismatch("rsp_o.rs2_ready", 8'($sampled(rsp_o.rs2_ready)),
                        8'($sampled(exp_rsp.rs2_ready)));

    // Run limit
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        logic                  ren_v;
        logic                  cdb_v;
        logic                  com_v;
        rename_pkg::arch_reg_t rs1;
        rename_pkg::arch_reg_t rs2;
        rename_pkg::arch_reg_t rd;
        rename_pkg::phys_tag_t cdb_tag;
        rename_pkg::phys_tag_t com_tag;
        int                    idx;
        void'($urandom(32'hfe00_8efa));
        reset_i        = 1'b1;
        ren_valid_i    = 1'b0;
        ren_req_i      = '0;
        cdb_valid_i    = 1'b0;
        cdb_tag_i      = '0;
        commit_valid_i = 1'b0;
        commit_tag_i   = '0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk_i);
        reset_i <= 1'b0;

        // Identity mapping right after reset
        request(5, 7, 0);
        request(31, 1, 0);
        request(0, 31, 0);
        idle();
        // Tags 32, 33, 34 in order, follower sees the new x3
        request(1, 2, 3);
        request(3, 3, 4);
        request(4, 0, 3);
        idle();
        // x3 on 34 and x4 on 33 both busy
        request(3, 4, 0);
        // Broadcast of 34 in the lookup cycle
        drive(1'b1, 4, 3, 0, 1'b1, 34, 1'b0, '0);
        request(3, 4, 0);
        drive(1'b0, '0, '0, '0, 1'b1, 33, 1'b0, '0);
        request(4, 3, 0);
        // x0 takes no tag and stays ready
        request(0, 0, 0);
        drive(1'b1, 0, 0, 0, 1'b1, 0, 1'b0, '0);
        request(0, 3, 0);
        // Use up 35..37, then recycle x3's old tag behind 38 and 39
        request(1, 1, 5);
        request(2, 2, 6);
        request(5, 6, 7);
        commit_oldest();
        request(8, 0, 8);
        request(9, 0, 9);
        request(10, 0, 10);
        // Empty list, these two are dropped
        request(3, 4, 11);
        request(3, 4, 11);
        commit_oldest();
        commit_oldest();
        request(3, 4, 11);
        request(11, 0, 12);
        idle();
        idle();

        // Random traffic
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            ren_v   = ($urandom % 4) != 0;
            rs1     = rename_pkg::arch_reg_t'($urandom % 32);
            rs2     = rename_pkg::arch_reg_t'($urandom % 32);
            rd      = rename_pkg::arch_reg_t'($urandom % 32);
            cdb_v   = ($urandom % 2) == 0;
            cdb_tag = rename_pkg::phys_tag_t'($urandom % NUM_PHYS);
            com_v   = (retired_m.size() != 0) && (($urandom % 2) == 0);
            com_tag = '0;
            if (com_v) begin
                idx     = int'($urandom % retired_m.size());
                com_tag = retired_m[idx];
                retired_m.delete(idx);
            end
            drive(ren_v, rs1, rs2, rd, cdb_v, cdb_tag, com_v, com_tag);
        end
        repeat (DRAIN_CYCLES) idle();

        $display("Errors: %0d, responses checked: %0d", errors, checks);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
